//--- logic/noc_loopback_pkg.sv
package noc_loopback_pkg;

  //////////////////////////////////////////////////////////////////////
  // Packet header, one 64 bit word
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [1:0]  pkt_type;
    logic [1:0]  flags;
    logic [11:0] seqnum;
    // Bytes including the header
    logic [15:0] length;
    logic [15:0] src_sid;
    logic [15:0] dst_sid;
  } pkt_hdr_t;

  // Known packet types
  localparam logic [1:0] PKT_DATA = 2'b00;
  localparam logic [1:0] PKT_CMD  = 2'b10;

  //////////////////////////////////////////////////////////////////////
  // Payload side types
  //////////////////////////////////////////////////////////////////////

  // One 32 bit sample, last marks end of packet
  typedef struct packed {
    logic        last;
    logic [31:0] data;
  } sample_t;

  // Settings write, low 40 bits of a command payload word
  typedef struct packed {
    logic [7:0]  addr;
    logic [31:0] data;
  } setting_t;

  // FIFO depths as address widths
  localparam int SAMPLE_FIFO_AW = 10;
  localparam int HDR_FIFO_AW    = 2;

  // Settings bank addresses
  localparam logic [7:0] SR_REPLY_SID = 8'd8;

endpackage

//--- logic/sample_fifo.sv
module sample_fifo #(
  parameter type T  = logic [31:0],
  parameter int  AW = 4
) (
  input  logic i_ce_clk,
  input  logic i_rst_n,
  // Write side
  input  logic i_push,
  input  T     i_data,
  output logic o_full,
  // Read side
  input  logic i_pop,
  output T     o_data,
  output logic o_empty
);

  localparam int DEPTH = 2 ** AW;

  // Entry storage
  T mem [DEPTH];

  // Pointers carry one extra wrap bit
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  //////////////////////////////////////////////////////////////////////
  // Pointers and storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge i_ce_clk) begin
    if (i_push) begin
      mem[wr_ptr[AW-1:0]] <= i_data;
    end
  end

  // Same index, different lap means full
  assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign o_empty = (wr_ptr == rd_ptr);

  // Head entry read straight out of the array
  assign o_data  = mem[rd_ptr[AW-1:0]];

  //////////////////////////////////////////////////////////////////////
  // Checks on the writer and reader
  //////////////////////////////////////////////////////////////////////

  a_no_push_full: assert property (
    @(posedge i_ce_clk) disable iff (!i_rst_n)
    i_push |-> !o_full
  );

  a_no_pop_empty: assert property (
    @(posedge i_ce_clk) disable iff (!i_rst_n)
    i_pop |-> !o_empty
  );

endmodule

//--- logic/str_sink.sv
module str_sink
  import noc_loopback_pkg::*;
(
  input  logic        i_ce_clk,
  input  logic        i_rst_n,
  // Input stream
  input  logic [63:0] i_tdata,
  input  logic        i_tlast,
  input  logic        i_tvalid,
  output logic        o_tready,
  // Sample FIFO write side
  output logic        o_smp_push,
  output sample_t     o_smp,
  input  logic        i_smp_full,
  // Header FIFO write side
  output logic        o_hdr_push,
  output pkt_hdr_t    o_hdr,
  input  logic        i_hdr_full,
  // Settings bank output
  output logic [15:0] o_reply_sid
);

  typedef enum logic [1:0] {
    S_INIT,
    S_HDR,
    S_PAY,
    S_LOW
  } state_t;

  state_t      state;
  logic [1:0]  type_q;
  logic [31:0] low_q;
  logic        last_q;
  logic [15:0] reply_sid_q;

  pkt_hdr_t    hdr_in;
  setting_t    set_in;
  logic        accept;
  logic        is_data;

  assign hdr_in  = pkt_hdr_t'(i_tdata);
  assign set_in  = setting_t'(i_tdata[39:0]);
  assign is_data = (type_q == PKT_DATA);
  assign accept  = i_tvalid && o_tready;

  //////////////////////////////////////////////////////////////////////
  // Flow control and FIFO pushes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (state)
      // Only data headers need room in the header FIFO
      S_HDR:   o_tready = (hdr_in.pkt_type != PKT_DATA) || !i_hdr_full;
      S_PAY:   o_tready = !is_data || !i_smp_full;
      default: o_tready = 1'b0;
    endcase
  end

  assign o_hdr_push = accept && (state == S_HDR) && (hdr_in.pkt_type == PKT_DATA);
  assign o_hdr      = hdr_in;

  // High half goes with the accepted word, low half a cycle later
  always_comb begin
    if (state == S_LOW) begin
      o_smp_push = !i_smp_full;
      o_smp      = '{last: last_q, data: low_q};
    end else begin
      o_smp_push = accept && (state == S_PAY) && is_data;
      o_smp      = '{last: 1'b0, data: i_tdata[63:32]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Header/payload state machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state       <= S_INIT;
      type_q      <= PKT_DATA;
      reply_sid_q <= '0;
    end else begin
      case (state)
        S_INIT: state <= S_HDR;
        S_HDR: begin
          if (accept) begin
            type_q <= hdr_in.pkt_type;
            state  <= S_PAY;
          end
        end
        S_PAY: begin
          if (accept) begin
            if (is_data) begin
              state <= S_LOW;
            end else if (i_tlast) begin
              state <= S_HDR;
            end
            // Settings write lands on the accepting edge
            if (type_q == PKT_CMD && set_in.addr == SR_REPLY_SID) begin
              reply_sid_q <= set_in.data[15:0];
            end
          end
        end
        S_LOW: begin
          if (o_smp_push) begin
            state <= last_q ? S_HDR : S_PAY;
          end
        end
        default: state <= S_HDR;
      endcase
    end
  end

  // Low half kept while the high half goes out
  always_ff @(posedge i_ce_clk) begin
    if (accept && state == S_PAY && is_data) begin
      low_q  <= i_tdata[31:0];
      last_q <= i_tlast;
    end
  end

  assign o_reply_sid = reply_sid_q;

  a_smp_push_room: assert property (
    @(posedge i_ce_clk) disable iff (!i_rst_n)
    o_smp_push |-> !i_smp_full
  );

  // A packet always carries at least one payload word
  a_no_tlast_on_hdr: assert property (
    @(posedge i_ce_clk) disable iff (!i_rst_n)
    (accept && state == S_HDR) |-> !i_tlast
  );

endmodule

//--- logic/str_source.sv
module str_source
  import noc_loopback_pkg::*;
(
  input  logic        i_ce_clk,
  input  logic        i_rst_n,
  // Header FIFO read side
  input  pkt_hdr_t    i_hdr,
  input  logic        i_hdr_empty,
  output logic        o_hdr_pop,
  // Sample FIFO read side
  input  sample_t     i_smp,
  input  logic        i_smp_empty,
  output logic        o_smp_pop,
  // Reply SID from the settings bank
  input  logic [15:0] i_reply_sid,
  // Output stream
  output logic [63:0] o_tdata,
  output logic        o_tlast,
  output logic        o_tvalid,
  input  logic        i_tready
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_HDR,
    S_PAY
  } state_t;

  state_t      state;
  logic        tvalid_q;
  logic [63:0] tdata_q;
  logic        tlast_q;
  // Set once the high sample is in place
  logic        half_q;
  logic [11:0] seqnum_q;

  pkt_hdr_t    hdr_out;

  //////////////////////////////////////////////////////////////////////
  // Header rewrite
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    hdr_out          = i_hdr;
    hdr_out.pkt_type = PKT_DATA;
    hdr_out.seqnum   = seqnum_q;
    hdr_out.src_sid  = i_hdr.dst_sid;
    hdr_out.dst_sid  = i_reply_sid;
  end

  assign o_hdr_pop = (state == S_IDLE) && !i_hdr_empty;
  // Samples only drained while the output register is free
  assign o_smp_pop = (state == S_PAY) && !tvalid_q && !i_smp_empty;

  //////////////////////////////////////////////////////////////////////
  // Output state machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state    <= S_IDLE;
      tvalid_q <= 1'b0;
      half_q   <= 1'b0;
      seqnum_q <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (o_hdr_pop) begin
            tvalid_q <= 1'b1;
            seqnum_q <= seqnum_q + 1'b1;
            state    <= S_HDR;
          end
        end
        S_HDR: begin
          if (i_tready) begin
            tvalid_q <= 1'b0;
            half_q   <= 1'b0;
            state    <= S_PAY;
          end
        end
        S_PAY: begin
          if (tvalid_q) begin
            if (i_tready) begin
              tvalid_q <= 1'b0;
              if (tlast_q) begin
                state <= S_IDLE;
              end
            end
          end else if (o_smp_pop) begin
            half_q   <= !half_q;
            tvalid_q <= half_q;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Output word register, high sample then low sample
  always_ff @(posedge i_ce_clk) begin
    if (o_hdr_pop) begin
      tdata_q <= hdr_out;
      tlast_q <= 1'b0;
    end else if (o_smp_pop) begin
      if (!half_q) begin
        tdata_q[63:32] <= i_smp.data;
      end else begin
        tdata_q[31:0] <= i_smp.data;
        tlast_q       <= i_smp.last;
      end
    end
  end

  assign o_tdata  = tdata_q;
  assign o_tlast  = tlast_q;
  assign o_tvalid = tvalid_q;

  a_hold_stalled: assert property (
    @(posedge i_ce_clk) disable iff (!i_rst_n)
    (o_tvalid && !i_tready) |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast)
  );

endmodule

//--- logic/noc_fifo_loopback.sv
module noc_fifo_loopback
  import noc_loopback_pkg::*;
(
  input  logic        i_ce_clk,
  input  logic        i_rst_n,
  // Input stream
  input  logic [63:0] i_tdata,
  input  logic        i_tlast,
  input  logic        i_tvalid,
  output logic        o_tready,
  // Output stream
  output logic [63:0] o_tdata,
  output logic        o_tlast,
  output logic        o_tvalid,
  input  logic        i_tready
);

  //////////////////////////////////////////////////////////////////////
  // Internal connections
  //////////////////////////////////////////////////////////////////////

  sample_t     smp_wr;
  sample_t     smp_rd;
  logic        smp_push;
  logic        smp_pop;
  logic        smp_full;
  logic        smp_empty;

  pkt_hdr_t    hdr_wr;
  pkt_hdr_t    hdr_rd;
  logic        hdr_push;
  logic        hdr_pop;
  logic        hdr_full;
  logic        hdr_empty;

  logic [15:0] reply_sid;

  //////////////////////////////////////////////////////////////////////
  // Sink, FIFOs, source
  //////////////////////////////////////////////////////////////////////

  str_sink sink0 (
    .i_ce_clk    (i_ce_clk),
    .i_rst_n     (i_rst_n),
    .i_tdata     (i_tdata),
    .i_tlast     (i_tlast),
    .i_tvalid    (i_tvalid),
    .o_tready    (o_tready),
    .o_smp_push  (smp_push),
    .o_smp       (smp_wr),
    .i_smp_full  (smp_full),
    .o_hdr_push  (hdr_push),
    .o_hdr       (hdr_wr),
    .i_hdr_full  (hdr_full),
    .o_reply_sid (reply_sid)
  );

  // Deep sample buffer
  sample_fifo #(.T(sample_t), .AW(SAMPLE_FIFO_AW)) smp_fifo0 (
    .i_ce_clk (i_ce_clk),
    .i_rst_n  (i_rst_n),
    .i_push   (smp_push),
    .i_data   (smp_wr),
    .o_full   (smp_full),
    .i_pop    (smp_pop),
    .o_data   (smp_rd),
    .o_empty  (smp_empty)
  );

  // Headers of packets in flight
  sample_fifo #(.T(pkt_hdr_t), .AW(HDR_FIFO_AW)) hdr_fifo0 (
    .i_ce_clk (i_ce_clk),
    .i_rst_n  (i_rst_n),
    .i_push   (hdr_push),
    .i_data   (hdr_wr),
    .o_full   (hdr_full),
    .i_pop    (hdr_pop),
    .o_data   (hdr_rd),
    .o_empty  (hdr_empty)
  );

  str_source source0 (
    .i_ce_clk    (i_ce_clk),
    .i_rst_n     (i_rst_n),
    .i_hdr       (hdr_rd),
    .i_hdr_empty (hdr_empty),
    .o_hdr_pop   (hdr_pop),
    .i_smp       (smp_rd),
    .i_smp_empty (smp_empty),
    .o_smp_pop   (smp_pop),
    .i_reply_sid (reply_sid),
    .o_tdata     (o_tdata),
    .o_tlast     (o_tlast),
    .o_tvalid    (o_tvalid),
    .i_tready    (i_tready)
  );

endmodule

//--- dv/tb_clock_gen.sv
module tb_clock_gen (
  input  logic i_rst_req,
  output logic o_clk,
  output logic o_rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  logic por_done;

  // 8 ns period
  initial begin
    o_clk = 1'b0;
    forever #4 o_clk = ~o_clk;
  end

  // Power-on reset for 4 cycles, released on a falling edge
  initial begin
    por_done = 1'b0;
    repeat (4) @(posedge o_clk);
    @(negedge o_clk);
    por_done = 1'b1;
  end

  assign o_rst_n = por_done && !i_rst_req;

endmodule

//--- dv/tb_checker.sv
module tb_checker
  import noc_loopback_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_rst_n,
  // Input stream of the DUT
  input  logic [63:0] i_in_tdata,
  input  logic        i_in_tlast,
  input  logic        i_in_tvalid,
  input  logic        i_in_tready,
  // Output stream of the DUT
  input  logic [63:0] i_out_tdata,
  input  logic        i_out_tlast,
  input  logic        i_out_tvalid,
  input  logic        i_out_tready,
  output int          o_err_cnt,
  output int          o_pending
);

  timeunit 1ns;
  timeprecision 100ps;

  // Expected output words, tlast in bit 64
  logic [64:0] exp_q [$];
  logic [64:0] exp_word;
  logic        in_hdr;
  logic [1:0]  cur_type;
  logic [15:0] model_sid;
  logic [11:0] model_seq;
  pkt_hdr_t    hdr_in;
  pkt_hdr_t    hdr_exp;
  setting_t    set_in;

  initial begin
    o_err_cnt = 0;
    o_pending = 0;
  end

  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      exp_q.delete();
      in_hdr    = 1'b1;
      model_sid = '0;
      model_seq = '0;
    end else begin
      ////////////////////////////////////////////////////////////////////
      // Predict from accepted input words
      ////////////////////////////////////////////////////////////////////
      if (i_in_tvalid && i_in_tready) begin
        if (in_hdr) begin
          hdr_in   = pkt_hdr_t'(i_in_tdata);
          cur_type = hdr_in.pkt_type;
          in_hdr   = 1'b0;
          if (hdr_in.pkt_type == PKT_DATA) begin
            hdr_exp         = hdr_in;
            hdr_exp.seqnum  = model_seq;
            hdr_exp.src_sid = hdr_in.dst_sid;
            hdr_exp.dst_sid = model_sid;
            exp_q.push_back({1'b0, hdr_exp});
            model_seq = model_seq + 1'b1;
          end
        end else begin
          if (cur_type == PKT_DATA) begin
            exp_q.push_back({i_in_tlast, i_in_tdata});
          end else if (cur_type == PKT_CMD) begin
            set_in = setting_t'(i_in_tdata[39:0]);
            if (set_in.addr == SR_REPLY_SID) begin
              model_sid = set_in.data[15:0];
            end
          end
          if (i_in_tlast) begin
            in_hdr = 1'b1;
          end
        end
      end
      ////////////////////////////////////////////////////////////////////
      // Compare accepted output words
      ////////////////////////////////////////////////////////////////////
      if (i_out_tvalid && i_out_tready) begin
        if (exp_q.size() == 0) begin
          $display("output word %h arrived while no word was expected", i_out_tdata);
          o_err_cnt = o_err_cnt + 1;
        end else begin
          exp_word = exp_q.pop_front();
          if (i_out_tdata !== exp_word[63:0]) begin
            $display("[ERROR] o_tdata expected %h got %h", exp_word[63:0], i_out_tdata);
            o_err_cnt = o_err_cnt + 1;
          end
          if (i_out_tlast !== exp_word[64]) begin
            $display("[ERROR] o_tlast expected %h got %h", exp_word[64], i_out_tlast);
            o_err_cnt = o_err_cnt + 1;
          end
        end
      end
    end
    o_pending = exp_q.size();
  end

endmodule

//--- dv/tb_noc_fifo_loopback.sv
module tb_noc_fifo_loopback
  import noc_loopback_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LOOP_PKTS    = 12;
  localparam int BP_PKTS      = 10;
  localparam int MAX_LEN      = 40;
  localparam int SHORT_LEN    = 8;
  localparam int BIG_LEN      = 600;
  // Worst case word count over all tests
  localparam int STIM_WORDS   = (LOOP_PKTS + BP_PKTS + 5) * (MAX_LEN + 1) +
                                11 * (SHORT_LEN + 1) + 6 * 2 + (BIG_LEN + 1) + 31;
  localparam int WD_CYCLES    = STIM_WORDS * 4 + 2000;
  localparam int DRAIN_CYCLES = 4000;
  localparam int STALL_LIMIT  = 16;

  // Downstream ready modes
  localparam int RDY_ON   = 0;
  localparam int RDY_RAND = 1;
  localparam int RDY_HOLD = 2;

  logic        clk;
  logic        rst_n;
  logic        rst_req;
  logic [63:0] in_tdata;
  logic        in_tlast;
  logic        in_tvalid;
  logic        in_tready;
  logic [63:0] out_tdata;
  logic        out_tlast;
  logic        out_tvalid;
  logic        out_tready;

  int          chk_errs;
  int          pending;
  int          tb_errs;
  int          errs_at_start;
  int          n_pass;
  int          n_fail;
  int          rdy_mode;
  int          stall_run;
  int          stall_hits;
  int          hold_base;
  logic [31:0] rng;
  logic [31:0] rdy_rng;

  tb_clock_gen clk_gen0 (.i_rst_req(rst_req), .o_clk(clk), .o_rst_n(rst_n));

  noc_fifo_loopback dut0 (
    .i_ce_clk (clk),
    .i_rst_n  (rst_n),
    .i_tdata  (in_tdata),
    .i_tlast  (in_tlast),
    .i_tvalid (in_tvalid),
    .o_tready (in_tready),
    .o_tdata  (out_tdata),
    .o_tlast  (out_tlast),
    .o_tvalid (out_tvalid),
    .i_tready (out_tready)
  );

  tb_checker chk0 (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_in_tdata   (in_tdata),
    .i_in_tlast   (in_tlast),
    .i_in_tvalid  (in_tvalid),
    .i_in_tready  (in_tready),
    .i_out_tdata  (out_tdata),
    .i_out_tlast  (out_tlast),
    .i_out_tvalid (out_tvalid),
    .i_out_tready (out_tready),
    .o_err_cnt    (chk_errs),
    .o_pending    (pending)
  );

  //////////////////////////////////////////////////////////////////////
  // Random numbers and stimulus tasks
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic int rand_len(input int max_len);
    return 1 + int'(next_rand() % 32'(max_len));
  endfunction

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic send_word(input logic [63:0] data, input logic last);
    in_tdata  = data;
    in_tlast  = last;
    in_tvalid = 1'b1;
    @(posedge clk);
    while (!in_tready) @(posedge clk);
    @(negedge clk);
    in_tvalid = 1'b0;
  endtask

  task automatic send_packet(input logic [1:0] ptype, input int n_words);
    pkt_hdr_t    hdr;
    logic [63:0] word;
    int          i;
    hdr          = pkt_hdr_t'({next_rand(), next_rand()});
    hdr.pkt_type = ptype;
    hdr.length   = 16'((n_words + 1) * 8);
    send_word(hdr, 1'b0);
    for (i = 0; i < n_words; i++) begin
      word = {next_rand(), next_rand()};
      send_word(word, i == n_words - 1);
    end
  endtask

  task automatic send_cmd(input logic [7:0] addr, input logic [31:0] data);
    pkt_hdr_t hdr;
    setting_t set;
    hdr          = pkt_hdr_t'({next_rand(), next_rand()});
    hdr.pkt_type = PKT_CMD;
    hdr.length   = 16'd16;
    set.addr     = addr;
    set.data     = data;
    send_word(hdr, 1'b0);
    send_word({24'h0, set}, 1'b1);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pending != 0 && n < DRAIN_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (pending != 0) begin
      $display("output did not drain, %0d words still expected", pending);
      tb_errs++;
    end
  endtask

  task automatic record_result(input string name);
    int errs;
    errs = chk_errs + tb_errs;
    if (errs == errs_at_start) begin
      $display("test %-13s ok", name);
      n_pass++;
    end else begin
      $display("test %-13s failed with %0d errors", name, errs - errs_at_start);
      n_fail++;
    end
    errs_at_start = errs;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Downstream ready and stall watch
  //////////////////////////////////////////////////////////////////////

  initial begin
    out_tready = 1'b1;
    rdy_rng    = 32'hedaf;
    forever begin
      @(negedge clk);
      case (rdy_mode)
        RDY_RAND: begin
          rdy_rng    = xorshift(rdy_rng);
          out_tready = (rdy_rng[1:0] != 2'b00);
        end
        // Held low until the input side has stalled for a while
        RDY_HOLD: out_tready = (stall_hits != hold_base);
        default:  out_tready = 1'b1;
      endcase
    end
  end

  always @(posedge clk) begin
    if (in_tvalid && !in_tready) begin
      stall_run <= stall_run + 1;
      if (stall_run == STALL_LIMIT) begin
        stall_hits <= stall_hits + 1;
      end
    end else begin
      stall_run <= 0;
    end
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    int n;
    in_tdata      = '0;
    in_tlast      = 1'b0;
    in_tvalid     = 1'b0;
    rst_req       = 1'b0;
    rng           = 32'hedaf;
    rdy_mode      = RDY_ON;
    hold_base     = 0;
    tb_errs       = 0;
    errs_at_start = 0;
    n_pass        = 0;
    n_fail        = 0;
    wait (rst_n);
    @(negedge clk);

    for (i = 0; i < LOOP_PKTS; i++) begin
      send_packet(PKT_DATA, rand_len(MAX_LEN));
    end
    wait_drain();
    record_result("loopback");

    // Reply SID only moves between fully drained packets
    send_packet(PKT_DATA, rand_len(SHORT_LEN));
    wait_drain();
    send_cmd(SR_REPLY_SID, next_rand());
    send_packet(PKT_DATA, rand_len(SHORT_LEN));
    wait_drain();
    send_cmd(8'd5, next_rand());
    send_packet(PKT_DATA, rand_len(SHORT_LEN));
    wait_drain();
    send_cmd(SR_REPLY_SID, next_rand());
    send_packet(PKT_DATA, rand_len(SHORT_LEN));
    wait_drain();
    record_result("settings");

    send_packet(PKT_DATA, rand_len(SHORT_LEN));
    send_cmd(8'd3, next_rand());
    send_packet(PKT_DATA, rand_len(SHORT_LEN));
    send_packet(2'b01, rand_len(SHORT_LEN));
    send_packet(PKT_DATA, rand_len(SHORT_LEN));
    send_cmd(8'd3, next_rand());
    send_packet(PKT_DATA, rand_len(SHORT_LEN));
    send_packet(PKT_DATA, rand_len(SHORT_LEN));
    wait_drain();
    record_result("sequence");

    send_packet(PKT_DATA, rand_len(MAX_LEN));
    send_packet(2'b01, rand_len(MAX_LEN));
    send_packet(PKT_DATA, rand_len(MAX_LEN));
    send_packet(2'b11, rand_len(MAX_LEN));
    send_packet(PKT_DATA, rand_len(MAX_LEN));
    wait_drain();
    record_result("unknown_type");

    rdy_mode = RDY_RAND;
    for (i = 0; i < BP_PKTS; i++) begin
      send_packet(PKT_DATA, rand_len(MAX_LEN));
    end
    wait_drain();
    hold_base = stall_hits;
    rdy_mode  = RDY_HOLD;
    send_packet(PKT_DATA, BIG_LEN);
    wait_drain();
    if (stall_hits == hold_base) begin
      $display("o_tready never stalled while the output was held off");
      tb_errs++;
    end
    rdy_mode = RDY_ON;
    record_result("back_pressure");

    send_cmd(SR_REPLY_SID, 32'h0000_5a5a);
    send_packet(PKT_DATA, 30);
    n = 0;
    while (!out_tvalid && n < 100) begin
      @(negedge clk);
      n++;
    end
    rst_req = 1'b1;
    repeat (4) begin
      @(negedge clk);
      if (out_tvalid !== 1'b0) begin
        $display("[ERROR] o_tvalid expected %h got %h", 1'b0, out_tvalid);
        tb_errs++;
      end
    end
    rst_req = 1'b0;
    repeat (2) @(negedge clk);
    // Seqnum and reply SID expected back at 0
    send_packet(PKT_DATA, rand_len(SHORT_LEN));
    wait_drain();
    record_result("reset");

    $display("summary: %0d ok, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- noc_fifo_loopback.f
logic/noc_loopback_pkg.sv
logic/sample_fifo.sv
logic/str_sink.sv
logic/str_source.sv
logic/noc_fifo_loopback.sv
dv/tb_clock_gen.sv
dv/tb_checker.sv
dv/tb_noc_fifo_loopback.sv
